/* design/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ########################################
// bus decoding
// ########################################

// upper address bits that pick one of the slave slots
`define SLAVE_SEL_WIDTH     4

// RAM depth as a word address width
`define TCM_ADDR_WIDTH      8

// ########################################
// reset and serial timing
// ########################################

// cycles the raw reset must stay high before release
`define RST_DEB_LENGTH      4
`define UART_CLKS_PER_BIT   8

`endif

/* design/soc_bus_pkg.sv */
`default_nettype none

`include "soc_config.svh"

package soc_bus_pkg;

    // slot number taken from the upper address bits
    // slots not listed here are unmapped and read zero
    typedef enum logic [`SLAVE_SEL_WIDTH-1:0]
    {
        SLV_TCM     = `SLAVE_SEL_WIDTH'(0),
        SLV_UART    = `SLAVE_SEL_WIDTH'(1)
    } slave_id_e;

endpackage

`default_nettype wire

/* design/soc_uart_pkg.sv */
`default_nettype none

package soc_uart_pkg;

    // register index, address bits 3:2
    typedef enum logic [1:0]
    {
        REG_TXDATA  = 2'd0,
        REG_RXDATA  = 2'd1,
        REG_STATUS  = 2'd2
    } uart_reg_e;

    typedef enum logic [1:0]
    {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } uart_tx_state_e;

    typedef enum logic [1:0]
    {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } uart_rx_state_e;

endpackage

`default_nettype wire

/* design/reset_debounce.sv */
`default_nettype none

`include "soc_config.svh"

module reset_debounce
(
    input   wire        w_clk,
    input   wire        i_rst_n,
    output  logic       o_rst_n
);

    localparam int LEN = `RST_DEB_LENGTH;
    localparam int CNT_W = $clog2(LEN + 1);

    logic [CNT_W-1:0]   r_cnt;

    // any low level on the raw reset restarts the count
    always_ff @(posedge w_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_cnt <= '0;
            o_rst_n <= 1'b0;
        end
        else if (r_cnt != CNT_W'(LEN))
        begin
            r_cnt <= r_cnt + 1'b1;
            if (r_cnt == CNT_W'(LEN - 1))
                o_rst_n <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/bus_decoder.sv */
`default_nettype none

`include "soc_config.svh"

module bus_decoder
    import soc_bus_pkg::*;
(
    input   wire                w_clk,
    input   wire                i_rst_n,
    input   wire                i_stb,
    input   wire                i_cyc,
    input   wire slave_id_e     i_addr_sel,
    input   wire [31:0]         i_tcm_dat,
    input   wire                i_tcm_ack,
    input   wire [31:0]         i_uart_dat,
    input   wire                i_uart_ack,
    output  logic               o_tcm_sel,
    output  logic               o_uart_sel,
    output  logic [31:0]        o_dat,
    output  logic               o_ack
);

    logic   w_active;
    logic   w_unmapped;
    logic   r_un_ack;
    logic   r_un_done;

    assign w_active = i_stb & i_cyc;
    assign o_tcm_sel = w_active && (i_addr_sel == SLV_TCM);
    assign o_uart_sel = w_active && (i_addr_sel == SLV_UART);
    assign w_unmapped = w_active & ~o_tcm_sel & ~o_uart_sel;

    // unmapped slots answer on their own so the master never stalls
    always_ff @(posedge w_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_un_ack <= 1'b0;
            r_un_done <= 1'b0;
        end
        else
        begin
            r_un_ack <= w_unmapped & ~r_un_ack & ~r_un_done;
            r_un_done <= w_unmapped & (r_un_done | r_un_ack);
        end
    end

    always_comb
    begin
        case (i_addr_sel)
            SLV_TCM:
            begin
                o_dat = i_tcm_dat;
                o_ack = i_tcm_ack;
            end
            SLV_UART:
            begin
                o_dat = i_uart_dat;
                o_ack = i_uart_ack;
            end
            default:
            begin
                o_dat = '0;
                o_ack = r_un_ack;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/tcm_ram.sv */
`default_nettype none

`include "soc_config.svh"

module tcm_ram
(
    input   wire                            w_clk,
    input   wire                            i_rst_n,
    input   wire                            i_sel,
    input   wire [`TCM_ADDR_WIDTH-1:0]      i_addr,
    input   wire                            i_we,
    input   wire [3:0]                      i_be,
    input   wire [31:0]                     i_dat,
    output  logic [31:0]                    o_dat,
    output  logic                           o_ack
);

    logic [31:0]    r_mem [0:(2**`TCM_ADDR_WIDTH)-1];
    logic           r_done;
    logic           w_access;

    // first cycle of a select only
    assign w_access = i_sel & ~o_ack & ~r_done;

    always_ff @(posedge w_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_ack <= 1'b0;
            r_done <= 1'b0;
        end
        else
        begin
            o_ack <= w_access;
            r_done <= i_sel & (r_done | o_ack);
        end
    end

    always_ff @(posedge w_clk)
    begin
        if (w_access)
        begin
            if (i_we)
            begin
                for (int i = 0; i < 4; i++)
                    if (i_be[i])
                        r_mem[i_addr][i*8 +: 8] <= i_dat[i*8 +: 8];
            end
            o_dat <= r_mem[i_addr];
        end
    end

endmodule

`default_nettype wire

/* design/uart_periph.sv */
`default_nettype none

`include "soc_config.svh"

module uart_periph
    import soc_uart_pkg::*;
(
    input   wire                w_clk,
    input   wire                i_rst_n,
    input   wire                i_sel,
    input   wire [1:0]          i_reg,
    input   wire                i_we,
    input   wire [7:0]          i_dat,
    input   wire                i_rxd,
    output  logic [31:0]        o_dat,
    output  logic               o_ack,
    output  logic               o_txd
);

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CNT_W = (CPB > 1) ? $clog2(CPB) : 1;
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CPB - 1);
    localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'(CPB / 2 - 1);

    uart_reg_e          w_reg;
    logic               r_done;
    logic               w_access;
    logic               w_tx_start;
    logic               w_rx_read;
    logic               w_tx_busy;

    uart_tx_state_e     r_tx_state;
    logic [CNT_W-1:0]   r_tx_cnt;
    logic [2:0]         r_tx_bit;
    logic [7:0]         r_tx_shift;

    logic [2:0]         r_rx_sync;
    uart_rx_state_e     r_rx_state;
    logic [CNT_W-1:0]   r_rx_cnt;
    logic [2:0]         r_rx_bit;
    logic [7:0]         r_rx_shift;
    logic [7:0]         r_rx_data;
    logic               r_rx_valid;

    // ########################################
    // register front end
    // ########################################

    assign w_reg = uart_reg_e'(i_reg);
    assign w_access = i_sel & ~o_ack & ~r_done;
    assign w_tx_busy = (r_tx_state != TX_IDLE);
    // a write while busy is acked but never reaches the shifter
    assign w_tx_start = w_access & i_we & (w_reg == REG_TXDATA) & ~w_tx_busy;
    assign w_rx_read = w_access & ~i_we & (w_reg == REG_RXDATA);

    always_ff @(posedge w_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_ack <= 1'b0;
            r_done <= 1'b0;
        end
        else
        begin
            o_ack <= w_access;
            r_done <= i_sel & (r_done | o_ack);
        end
    end

    always_ff @(posedge w_clk)
    begin
        if (w_access)
        begin
            case (w_reg)
                REG_RXDATA: o_dat <= {24'd0, r_rx_data};
                REG_STATUS: o_dat <= {30'd0, r_rx_valid, w_tx_busy};
                default:    o_dat <= '0;
            endcase
        end
    end

    // ########################################
    // transmitter
    // ########################################

    always_ff @(posedge w_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_tx_state <= TX_IDLE;
            r_tx_cnt <= '0;
            r_tx_bit <= '0;
            r_tx_shift <= '0;
            o_txd <= 1'b1;
        end
        else
        begin
            r_tx_cnt <= (r_tx_cnt == BIT_LAST) ? '0 : r_tx_cnt + 1'b1;
            case (r_tx_state)
                TX_IDLE:
                begin
                    r_tx_cnt <= '0;
                    if (w_tx_start)
                    begin
                        r_tx_shift <= i_dat;
                        o_txd <= 1'b0;
                        r_tx_state <= TX_START;
                    end
                end
                TX_START:
                    if (r_tx_cnt == BIT_LAST)
                    begin
                        o_txd <= r_tx_shift[0];
                        r_tx_bit <= '0;
                        r_tx_state <= TX_DATA;
                    end
                TX_DATA:
                    if (r_tx_cnt == BIT_LAST)
                    begin
                        // lsb first so the next bit already sits at index 1
                        r_tx_shift <= {1'b1, r_tx_shift[7:1]};
                        o_txd <= (r_tx_bit == 3'd7) ? 1'b1 : r_tx_shift[1];
                        r_tx_bit <= r_tx_bit + 1'b1;
                        if (r_tx_bit == 3'd7)
                            r_tx_state <= TX_STOP;
                    end
                default:
                    if (r_tx_cnt == BIT_LAST)
                        r_tx_state <= TX_IDLE;
            endcase
        end
    end

    // ########################################
    // receiver
    // ########################################

    always_ff @(posedge w_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_rx_sync <= '1;
            r_rx_state <= RX_IDLE;
            r_rx_cnt <= '0;
            r_rx_bit <= '0;
            r_rx_shift <= '0;
            r_rx_data <= '0;
            r_rx_valid <= 1'b0;
        end
        else
        begin
            r_rx_sync <= {r_rx_sync[1:0], i_rxd};
            r_rx_cnt <= r_rx_cnt + 1'b1;
            if (w_rx_read)
                r_rx_valid <= 1'b0;
            case (r_rx_state)
                RX_IDLE:
                begin
                    r_rx_cnt <= '0;
                    // falling edge on the synchronized line
                    if (r_rx_sync[2] && !r_rx_sync[1])
                        r_rx_state <= RX_START;
                end
                RX_START:
                    if (r_rx_cnt == BIT_HALF)
                    begin
                        r_rx_cnt <= '0;
                        r_rx_bit <= '0;
                        r_rx_state <= r_rx_sync[1] ? RX_IDLE : RX_DATA;
                    end
                RX_DATA:
                    if (r_rx_cnt == BIT_LAST)
                    begin
                        r_rx_cnt <= '0;
                        r_rx_shift <= {r_rx_sync[1], r_rx_shift[7:1]};
                        r_rx_bit <= r_rx_bit + 1'b1;
                        if (r_rx_bit == 3'd7)
                            r_rx_state <= RX_STOP;
                    end
                default:
                    if (r_rx_cnt == BIT_LAST)
                    begin
                        // framing error drops the byte
                        if (r_rx_sync[1])
                        begin
                            r_rx_data <= r_rx_shift;
                            r_rx_valid <= 1'b1;
                        end
                        r_rx_state <= RX_IDLE;
                    end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/soc_top.sv */
`default_nettype none

`include "soc_config.svh"

module soc_top
    import soc_bus_pkg::*;
(
    input   wire                w_clk,
    input   wire                i_rst_n,
    input   wire [31:0]         i_wb_adr,
    input   wire [31:0]         i_wb_dat,
    input   wire [3:0]          i_wb_sel,
    input   wire                i_wb_we,
    input   wire                i_wb_stb,
    input   wire                i_wb_cyc,
    input   wire                i_rxd,
    output  logic [31:0]        o_wb_dat,
    output  logic               o_wb_ack,
    output  logic               o_txd
);

    logic           w_rst_n;
    slave_id_e      w_slot;
    logic           w_tcm_sel;
    logic           w_uart_sel;
    logic [31:0]    w_tcm_dat;
    logic           w_tcm_ack;
    logic [31:0]    w_uart_dat;
    logic           w_uart_ack;

    reset_debounce u_rst_deb
    (
        .w_clk          (w_clk),
        .i_rst_n        (i_rst_n),
        .o_rst_n        (w_rst_n)
    );

    // ########################################
    // interconnect
    // ########################################

    assign w_slot = slave_id_e'(i_wb_adr[31 -: `SLAVE_SEL_WIDTH]);

    bus_decoder u_decoder
    (
        .w_clk          (w_clk),
        .i_rst_n        (w_rst_n),
        .i_stb          (i_wb_stb),
        .i_cyc          (i_wb_cyc),
        .i_addr_sel     (w_slot),
        .i_tcm_dat      (w_tcm_dat),
        .i_tcm_ack      (w_tcm_ack),
        .i_uart_dat     (w_uart_dat),
        .i_uart_ack     (w_uart_ack),
        .o_tcm_sel      (w_tcm_sel),
        .o_uart_sel     (w_uart_sel),
        .o_dat          (o_wb_dat),
        .o_ack          (o_wb_ack)
    );

    // ########################################
    // slaves
    // ########################################

    tcm_ram u_tcm
    (
        .w_clk          (w_clk),
        .i_rst_n        (w_rst_n),
        .i_sel          (w_tcm_sel),
        .i_addr         (i_wb_adr[(`TCM_ADDR_WIDTH+1):2]),
        .i_we           (i_wb_we),
        .i_be           (i_wb_sel),
        .i_dat          (i_wb_dat),
        .o_dat          (w_tcm_dat),
        .o_ack          (w_tcm_ack)
    );

    uart_periph u_uart
    (
        .w_clk          (w_clk),
        .i_rst_n        (w_rst_n),
        .i_sel          (w_uart_sel),
        .i_reg          (i_wb_adr[3:2]),
        .i_we           (i_wb_we),
        .i_dat          (i_wb_dat[7:0]),
        .i_rxd          (i_rxd),
        .o_dat          (w_uart_dat),
        .o_ack          (w_uart_ack),
        .o_txd          (o_txd)
    );

endmodule

`default_nettype wire

/* verification/tb_soc_top.sv */
`default_nettype none

`include "soc_config.svh"

module tb_soc_top
    import soc_uart_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int RST_LEN = `RST_DEB_LENGTH;

    typedef enum logic [1:0]
    {
        ST_BUS, ST_FRAME, ST_LOOP, ST_QUIET
    } step_kind_e;

    typedef struct packed
    {
        logic [7:0]     test;
        step_kind_e     kind;
        logic [31:0]    adr;
        logic           we;
        logic [3:0]     sel;
        logic [31:0]    wdat;
        logic [31:0]    exp_dat;
        logic           chk;
    } step_t;

    logic           w_clk;
    logic           i_rst_n;
    logic [31:0]    i_wb_adr;
    logic [31:0]    i_wb_dat;
    logic [3:0]     i_wb_sel;
    logic           i_wb_we;
    logic           i_wb_stb;
    logic           i_wb_cyc;
    logic           i_rxd;
    logic [31:0]    o_wb_dat;
    logic           o_wb_ack;
    logic           o_txd;

    logic [31:0]    model [0:(2**`TCM_ADDR_WIDTH)-1];
    logic [7:0]     tx_bytes [$];
    step_t          steps [$];
    integer         seed;
    int             err_count;
    int             test_errs;
    int             pass_tests;
    int             fail_tests;
    int             cycles;
    int             limit = 0;
    logic           r_loop;
    logic           reset_done;

    soc_top u_dut
    (
        .w_clk          (w_clk),
        .i_rst_n        (i_rst_n),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .i_wb_sel       (i_wb_sel),
        .i_wb_we        (i_wb_we),
        .i_wb_stb       (i_wb_stb),
        .i_wb_cyc       (i_wb_cyc),
        .i_rxd          (i_rxd),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .o_txd          (o_txd)
    );

    // the serial line idles high while loopback is off
    assign i_rxd = r_loop ? o_txd : 1'b1;

    initial
    begin
        w_clk = 1'b0;
        forever #50 w_clk = ~w_clk;
    end

    // ########################################
    // helpers
    // ########################################

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("ERROR at %0t ns: %s expected %08h actual %08h", $time, sig, exp_v, act_v);
        err_count++;
        test_errs++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        err_count++;
        test_errs++;
    endtask

    function automatic logic [31:0] uart_addr(input uart_reg_e r);
        return {4'h1, 24'd0, r, 2'b00};
    endfunction

    // selected lanes take the new byte and the others keep the old one
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] sel);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++)
            if (sel[i])
                result[i*8 +: 8] = new_word[i*8 +: 8];
        return result;
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset";
            2:       return "ram access";
            3:       return "unmapped access";
            4:       return "uart transmit";
            5:       return "uart receive";
            default: return "write while busy";
        endcase
    endfunction

    task automatic add_step(input logic [7:0] test, input step_kind_e kind,
                            input logic [31:0] adr, input logic we, input logic [3:0] sel,
                            input logic [31:0] wdat, input logic [31:0] exp_dat,
                            input logic chk);
        step_t st;
        st.test = test;
        st.kind = kind;
        st.adr = adr;
        st.we = we;
        st.sel = sel;
        st.wdat = wdat;
        st.exp_dat = exp_dat;
        st.chk = chk;
        steps.push_back(st);
    endtask

    task automatic report_test(input int n);
        $display("test %0d %s: %s", n, test_name(n), (test_errs == 0) ? "ok" : "failed");
        if (test_errs == 0)
            pass_tests++;
        else
            fail_tests++;
        test_errs = 0;
    endtask

    // ########################################
    // stimulus table
    // ########################################

    task automatic build_table();
        add_step(1, ST_BUS, 32'h0000_0080, 1'b1, 4'hf, 32'h0, 32'h0, 1'b0);
        add_step(1, ST_BUS, 32'h0000_0080, 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
        add_step(2, ST_BUS, 32'h0000_0000, 1'b1, 4'hf, 32'h0, 32'h0, 1'b0);
        add_step(2, ST_BUS, 32'h0000_0004, 1'b1, 4'hf, 32'h0, 32'h0, 1'b0);
        add_step(2, ST_BUS, 32'h0000_03fc, 1'b1, 4'hf, 32'h0, 32'h0, 1'b0);
        add_step(2, ST_BUS, 32'h0000_0100, 1'b1, 4'hf, 32'h0, 32'h0, 1'b0);
        add_step(2, ST_BUS, 32'h0000_0000, 1'b1, 4'h3, 32'h0, 32'h0, 1'b0);
        add_step(2, ST_BUS, 32'h0000_0004, 1'b1, 4'h8, 32'h0, 32'h0, 1'b0);
        add_step(2, ST_BUS, 32'h0000_03fc, 1'b1, 4'h5, 32'h0, 32'h0, 1'b0);
        add_step(2, ST_BUS, 32'h0000_0100, 1'b1, 4'h6, 32'h0, 32'h0, 1'b0);
        add_step(2, ST_BUS, 32'h0000_0000, 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
        add_step(2, ST_BUS, 32'h0000_0004, 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
        add_step(2, ST_BUS, 32'h0000_03fc, 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
        add_step(2, ST_BUS, 32'h0000_0100, 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
        add_step(3, ST_BUS, 32'h5000_0010, 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
        add_step(3, ST_BUS, 32'hf000_0004, 1'b1, 4'hf, 32'h5a5a_a5a5, 32'h0, 1'b0);
        add_step(3, ST_BUS, 32'h0000_0004, 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
        add_step(4, ST_BUS, uart_addr(REG_TXDATA), 1'b1, 4'h1, 32'ha5, 32'h0, 1'b0);
        add_step(4, ST_BUS, uart_addr(REG_STATUS), 1'b0, 4'hf, 32'h0, 32'h1, 1'b1);
        add_step(4, ST_FRAME, 32'h0, 1'b0, 4'h0, 32'h0, 32'ha5, 1'b1);
        add_step(4, ST_BUS, uart_addr(REG_STATUS), 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
        add_step(5, ST_LOOP, 32'h0, 1'b0, 4'h0, 32'h1, 32'h0, 1'b0);
        add_step(5, ST_BUS, uart_addr(REG_TXDATA), 1'b1, 4'h1, 32'h96, 32'h0, 1'b0);
        add_step(5, ST_FRAME, 32'h0, 1'b0, 4'h0, 32'h0, 32'h96, 1'b1);
        add_step(5, ST_BUS, uart_addr(REG_STATUS), 1'b0, 4'hf, 32'h0, 32'h2, 1'b1);
        add_step(5, ST_BUS, uart_addr(REG_RXDATA), 1'b0, 4'hf, 32'h0, 32'h96, 1'b1);
        add_step(5, ST_BUS, uart_addr(REG_STATUS), 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
        add_step(5, ST_LOOP, 32'h0, 1'b0, 4'h0, 32'h0, 32'h0, 1'b0);
        add_step(6, ST_BUS, uart_addr(REG_TXDATA), 1'b1, 4'h1, 32'h3c, 32'h0, 1'b0);
        add_step(6, ST_BUS, uart_addr(REG_TXDATA), 1'b1, 4'h1, 32'hc3, 32'h0, 1'b0);
        add_step(6, ST_FRAME, 32'h0, 1'b0, 4'h0, 32'h0, 32'h3c, 1'b1);
        add_step(6, ST_QUIET, 32'h0, 1'b0, 4'h0, 32'h0, 32'h0, 1'b0);
        add_step(6, ST_BUS, uart_addr(REG_STATUS), 1'b0, 4'hf, 32'h0, 32'h0, 1'b1);
    endtask

    // ########################################
    // bus master
    // ########################################

    task automatic bus_cycle(input logic [31:0] adr, input logic we, input logic [3:0] sel,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int     edges;
        logic   seen;
        @(posedge w_clk);
        #10;
        i_wb_adr = adr;
        i_wb_dat = wdat;
        i_wb_sel = sel;
        i_wb_we = we;
        i_wb_stb = 1'b1;
        i_wb_cyc = 1'b1;
        // the launch edge counts as the first
        edges = 1;
        seen = 1'b0;
        rdat = '0;
        while (!seen && edges < 9)
        begin
            @(posedge w_clk);
            edges++;
            @(negedge w_clk);
            if (o_wb_ack)
            begin
                seen = 1'b1;
                rdat = o_wb_dat;
            end
        end
        if (!seen)
            report_failure($sformatf("no acknowledge for address %08h within 8 cycles", adr));
        else if (edges != 2)
            report_mismatch("o_wb_ack latency", 32'd2, 32'(edges));
        @(posedge w_clk);
        #10;
        i_wb_stb = 1'b0;
        i_wb_cyc = 1'b0;
        i_wb_we = 1'b0;
        @(negedge w_clk);
        if (o_wb_ack)
            report_failure($sformatf("second acknowledge for address %08h", adr));
    endtask

    task automatic apply_step(input step_t st);
        logic [31:0]    wdat;
        logic [31:0]    rdat;
        logic [31:0]    exp_v;
        logic [7:0]     byte_seen;
        logic           is_ram;
        int             idx;
        int             low_samples;
        wdat = st.wdat;
        exp_v = st.exp_dat;
        is_ram = (st.adr[31 -: `SLAVE_SEL_WIDTH] == '0);
        idx = int'(st.adr[`TCM_ADDR_WIDTH+1:2]);
        low_samples = 0;
        case (st.kind)
            ST_BUS:
            begin
                if (st.we && is_ram)
                    wdat = $random(seed);
                bus_cycle(st.adr, st.we, st.sel, wdat, rdat);
                if (is_ram && st.we)
                    model[idx] = merge_lanes(model[idx], wdat, st.sel);
                else if (is_ram)
                    exp_v = model[idx];
                if (!st.we && st.chk && rdat !== exp_v)
                    report_mismatch("o_wb_dat", exp_v, rdat);
            end
            ST_FRAME:
            begin
                while (tx_bytes.size() == 0)
                    @(posedge w_clk);
                byte_seen = tx_bytes.pop_front();
                if (byte_seen !== st.exp_dat[7:0])
                    report_mismatch("o_txd frame", {24'd0, st.exp_dat[7:0]}, {24'd0, byte_seen});
            end
            ST_LOOP:
            begin
                @(posedge w_clk);
                #10;
                r_loop = st.wdat[0];
            end
            default:
            begin
                repeat (2 * CPB)
                begin
                    @(negedge w_clk);
                    if (o_txd !== 1'b1)
                        low_samples++;
                end
                if (low_samples != 0)
                    report_failure("o_txd left the idle level after the frame");
                if (tx_bytes.size() != 0)
                    report_failure("an extra frame appeared on o_txd");
            end
        endcase
    endtask

    // ########################################
    // serial monitor
    // ########################################

    initial
    begin
        logic [7:0] data;
        wait (reset_done);
        forever
        begin
            @(negedge w_clk);
            if (o_txd === 1'b0)
            begin
                // move to the middle of the start bit
                repeat (CPB / 2 - 1) @(negedge w_clk);
                if (o_txd !== 1'b0)
                    report_failure("start bit on o_txd ended too early");
                else
                begin
                    for (int b = 0; b < 8; b++)
                    begin
                        repeat (CPB) @(negedge w_clk);
                        data[b] = o_txd;
                    end
                    repeat (CPB) @(negedge w_clk);
                    if (o_txd !== 1'b1)
                        report_failure("stop bit on o_txd was low");
                    else
                    begin
                        repeat (CPB / 2) @(negedge w_clk);
                        tx_bytes.push_back(data);
                    end
                end
            end
        end
    end

    initial
    begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit)
        begin
            @(posedge w_clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ########################################
    // main sequence
    // ########################################

    initial
    begin
        int cur_test;
        i_rst_n = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        i_wb_sel = '0;
        i_wb_we = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_cyc = 1'b0;
        r_loop = 1'b0;
        reset_done = 1'b0;
        seed = 32'hd7eb;
        err_count = 0;
        test_errs = 0;
        pass_tests = 0;
        fail_tests = 0;
        build_table();
        limit = steps.size() * 4 + 3 * 10 * CPB + 100;

        // 3 reset cycles and then the debounce window
        // a RAM read is held on the bus and must not be acknowledged
        for (int i = 0; i < 3 + RST_LEN; i++)
        begin
            @(posedge w_clk);
            #10;
            if (i == 0)
            begin
                i_wb_stb = 1'b1;
                i_wb_cyc = 1'b1;
            end
            if (i == 2)
                i_rst_n = 1'b1;
            if (i == 2 + RST_LEN)
            begin
                i_wb_stb = 1'b0;
                i_wb_cyc = 1'b0;
            end
            @(negedge w_clk);
            if (o_wb_ack !== 1'b0)
                report_mismatch("o_wb_ack", 32'd0, {31'd0, o_wb_ack});
            if (o_txd !== 1'b1)
                report_mismatch("o_txd", 32'd1, {31'd0, o_txd});
        end
        reset_done = 1'b1;

        cur_test = 1;
        for (int i = 0; i < steps.size(); i++)
        begin
            if (int'(steps[i].test) != cur_test)
            begin
                report_test(cur_test);
                cur_test = int'(steps[i].test);
            end
            apply_step(steps[i]);
        end
        report_test(cur_test);

        $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
        if (err_count == 0 && fail_tests == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/soc_bus_pkg.sv
design/soc_uart_pkg.sv
design/reset_debounce.sv
design/bus_decoder.sv
design/tcm_ram.sv
design/uart_periph.sv
design/soc_top.sv
verification/tb_soc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_soc_top -o tb_soc_top \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/tb_soc_top) || { echo "$sim_out"; echo "simulator error"; exit 1; }
echo "$sim_out"

echo "$sim_out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
